// File: rtl/sysctl_pkg.sv
package sysctl_pkg;

	// ------------------------------
	// Bus words
	// ------------------------------
	typedef logic [31:0] wb_adr_t;
	typedef logic [31:0] wb_dat_t;

	// CSR word address, bank in the upper 4 bits
	typedef logic [9:0] csr_adr_t;
	localparam int CSR_REG_W = 6;

	// Peripheral pins and interrupt sources
	typedef logic [3:0] gpio_in_t;
	typedef logic [1:0] gpio_out_t;
	// Bit 0 GPIO, bit 1 timer 0, bit 2 timer 1
	typedef logic [2:0] irq_vec_t;

	typedef enum logic [1:0] {
		BR_IDLE,
		BR_ACCESS,
		BR_CAPTURE,
		BR_ACK
	} bridge_state_t;

	// ------------------------------
	// CSR map
	// ------------------------------
	localparam logic [3:0] CSR_BANK_GPIO   = 4'd1;
	localparam logic [3:0] CSR_BANK_TIMER0 = 4'd2;
	localparam logic [3:0] CSR_BANK_TIMER1 = 4'd3;
	localparam logic [3:0] CSR_BANK_IRQ    = 4'd4;

	localparam logic [CSR_REG_W-1:0] REG_GPIO_IN     = 6'd0;
	localparam logic [CSR_REG_W-1:0] REG_GPIO_OUT    = 6'd1;
	localparam logic [CSR_REG_W-1:0] REG_TMR_CTRL    = 6'd0;
	localparam logic [CSR_REG_W-1:0] REG_TMR_COMPARE = 6'd1;
	localparam logic [CSR_REG_W-1:0] REG_TMR_COUNTER = 6'd2;
	localparam logic [CSR_REG_W-1:0] REG_IRQ_PENDING = 6'd0;
	localparam logic [CSR_REG_W-1:0] REG_IRQ_MASK    = 6'd1;

	// Timer control word bits
	localparam int TMR_CTRL_EN = 0;
	localparam int TMR_CTRL_AR = 1;

	// Reset staging, in cycles after the trigger drops
	localparam int BOOT_RST_CYCLES = 128;
	localparam int SYS_RST_CYCLES  = 256;
	localparam int RST_CNT_W       = 9;

endpackage

// File: rtl/csr_bus_if.sv
interface csr_bus_if import sysctl_pkg::*; ();

	// Request side, same on every segment
	csr_adr_t csr_a;
	logic     csr_we;
	wb_dat_t  csr_dw;
	// Registered read word, zero when not addressed
	wb_dat_t  csr_dr;

	modport bridge (
		output csr_a,
		output csr_we,
		output csr_dw,
		input  csr_dr
	);

	modport periph (
		input  csr_a,
		input  csr_we,
		input  csr_dw,
		output csr_dr
	);

endinterface

// File: rtl/reset_seq.sv
module reset_seq import sysctl_pkg::*; (
	input  logic sys_clk,
	input  logic trigger_reset,
	output logic sys_rst_o,
	output logic boot_rst_n_o
);

	logic [RST_CNT_W-1:0] rst_cnt;

	// Counter value seen at the release edge of each reset
	// Count is SYS_RST_CYCLES + 1 - k before edge k
	logic sys_hold;
	logic boot_hold;

	assign sys_hold  = rst_cnt > RST_CNT_W'(1);
	assign boot_hold = rst_cnt > RST_CNT_W'(SYS_RST_CYCLES - BOOT_RST_CYCLES + 1);

	// Single down-counter, reloaded while the trigger is high
	always_ff @(posedge sys_clk) begin
		if (trigger_reset) begin
			rst_cnt <= RST_CNT_W'(SYS_RST_CYCLES);
		end else if (rst_cnt != '0) begin
			rst_cnt <= rst_cnt - RST_CNT_W'(1);
		end
	end

	// Boot device leaves reset first so it is ready when the system starts
	always_ff @(posedge sys_clk) begin
		if (trigger_reset) begin
			sys_rst_o    <= 1'b1;
			boot_rst_n_o <= 1'b0;
		end else begin
			sys_rst_o    <= sys_hold;
			boot_rst_n_o <= !boot_hold;
		end
	end

endmodule

// File: rtl/wb_csr_bridge.sv
module wb_csr_bridge import sysctl_pkg::*; (
	input  logic    sys_clk,
	input  logic    sys_rst_i,
	input  wb_adr_t wb_adr_i,
	input  wb_dat_t wb_dat_i,
	output wb_dat_t wb_dat_o,
	input  logic    wb_we_i,
	input  logic    wb_cyc_i,
	input  logic    wb_stb_i,
	output logic    wb_ack_o,
	csr_bus_if.bridge gpio_bus,
	csr_bus_if.bridge tmr0_bus,
	csr_bus_if.bridge tmr1_bus,
	csr_bus_if.bridge irq_bus
);

	bridge_state_t state;
	csr_adr_t      csr_a_q;
	logic          csr_we_q;
	wb_dat_t       csr_dw_q;

	// ------------------------------
	// Access sequencer
	// ------------------------------
	// Idle -> access -> capture -> ack -> idle
	// Strobe is not looked at in the ack cycle, so a held strobe is taken once
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			state    <= BR_IDLE;
			csr_a_q  <= '0;
			csr_we_q <= 1'b0;
		end else begin
			csr_we_q <= 1'b0;
			case (state)
				BR_IDLE: begin
					if (wb_cyc_i && wb_stb_i) begin
						// Byte address to word address
						csr_a_q  <= wb_adr_i[11:2];
						csr_we_q <= wb_we_i;
						state    <= BR_ACCESS;
					end
				end
				BR_ACCESS:  state <= BR_CAPTURE;
				BR_CAPTURE: state <= BR_ACK;
				default:    state <= BR_IDLE;
			endcase
		end
	end

	// Write data held for the whole access
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			csr_dw_q <= '0;
		end else if (state == BR_IDLE && wb_cyc_i && wb_stb_i) begin
			csr_dw_q <= wb_dat_i;
		end
	end

	// Peripheral words arrive one cycle after the address and are ORed together
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			wb_dat_o <= '0;
		end else if (state == BR_CAPTURE) begin
			wb_dat_o <= gpio_bus.csr_dr | tmr0_bus.csr_dr | tmr1_bus.csr_dr
				| irq_bus.csr_dr;
		end
	end

	assign wb_ack_o = (state == BR_ACK);

	// Same request on every segment
	assign gpio_bus.csr_a  = csr_a_q;
	assign gpio_bus.csr_we = csr_we_q;
	assign gpio_bus.csr_dw = csr_dw_q;
	assign tmr0_bus.csr_a  = csr_a_q;
	assign tmr0_bus.csr_we = csr_we_q;
	assign tmr0_bus.csr_dw = csr_dw_q;
	assign tmr1_bus.csr_a  = csr_a_q;
	assign tmr1_bus.csr_we = csr_we_q;
	assign tmr1_bus.csr_dw = csr_dw_q;
	assign irq_bus.csr_a   = csr_a_q;
	assign irq_bus.csr_we  = csr_we_q;
	assign irq_bus.csr_dw  = csr_dw_q;

endmodule

// File: rtl/sysctl_gpio.sv
module sysctl_gpio import sysctl_pkg::*; (
	input  logic      sys_clk,
	input  logic      sys_rst_i,
	input  gpio_in_t  gpio_i,
	output gpio_out_t gpio_o,
	output logic      irq_o,
	csr_bus_if.periph csr
);

	gpio_in_t gpio_s1;
	gpio_in_t gpio_s2;
	gpio_in_t gpio_prev;

	logic                 bank_hit;
	logic [CSR_REG_W-1:0] reg_idx;

	assign bank_hit = (csr.csr_a[$bits(csr_adr_t)-1:CSR_REG_W] == CSR_BANK_GPIO);
	assign reg_idx  = csr.csr_a[CSR_REG_W-1:0];

	// ------------------------------
	// Input sync and change detect
	// ------------------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			gpio_s1   <= '0;
			gpio_s2   <= '0;
			gpio_prev <= '0;
			irq_o     <= 1'b0;
		end else begin
			gpio_s1   <= gpio_i;
			gpio_s2   <= gpio_s1;
			gpio_prev <= gpio_s2;
			// Any bit toggled since last cycle
			irq_o     <= (gpio_s2 != gpio_prev);
		end
	end

	// Output register
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			gpio_o <= '0;
		end else if (csr.csr_we && bank_hit && reg_idx == REG_GPIO_OUT) begin
			gpio_o <= csr.csr_dw[$bits(gpio_out_t)-1:0];
		end
	end

	// Read port, zero outside the bank
	always_ff @(posedge sys_clk) begin
		csr.csr_dr <= '0;
		if (bank_hit) begin
			case (reg_idx)
				REG_GPIO_IN:  csr.csr_dr <= wb_dat_t'(gpio_s2);
				REG_GPIO_OUT: csr.csr_dr <= wb_dat_t'(gpio_o);
				default:      csr.csr_dr <= '0;
			endcase
		end
	end

endmodule

// File: rtl/sysctl_timer.sv
module sysctl_timer import sysctl_pkg::*; #(
	parameter logic [3:0] CSR_BANK = CSR_BANK_TIMER0
) (
	input  logic sys_clk,
	input  logic sys_rst_i,
	output logic irq_o,
	csr_bus_if.periph csr
);

	logic    en;
	logic    ar;
	wb_dat_t compare;
	wb_dat_t counter;
	wb_dat_t ctrl_word;

	logic                 bank_hit;
	logic                 wr_hit;
	logic [CSR_REG_W-1:0] reg_idx;

	assign bank_hit = (csr.csr_a[$bits(csr_adr_t)-1:CSR_REG_W] == CSR_BANK);
	assign reg_idx  = csr.csr_a[CSR_REG_W-1:0];
	assign wr_hit   = csr.csr_we && bank_hit;

	always_comb begin
		ctrl_word = '0;
		ctrl_word[TMR_CTRL_EN] = en;
		ctrl_word[TMR_CTRL_AR] = ar;
	end

	// ------------------------------
	// Counter and match
	// ------------------------------
	// CSR writes come last and override the count path
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			en      <= 1'b0;
			ar      <= 1'b0;
			compare <= '0;
			counter <= '0;
			irq_o   <= 1'b0;
		end else begin
			irq_o <= 1'b0;
			if (en) begin
				if (counter == compare) begin
					// Wrap and flag in the same cycle
					counter <= '0;
					irq_o   <= 1'b1;
					// One-shot stops itself
					if (!ar) begin
						en <= 1'b0;
					end
				end else begin
					counter <= counter + 32'd1;
				end
			end
			if (wr_hit) begin
				case (reg_idx)
					REG_TMR_CTRL: begin
						en <= csr.csr_dw[TMR_CTRL_EN];
						ar <= csr.csr_dw[TMR_CTRL_AR];
					end
					REG_TMR_COMPARE: compare <= csr.csr_dw;
					REG_TMR_COUNTER: counter <= csr.csr_dw;
					default: ;
				endcase
			end
		end
	end

	// Read port
	always_ff @(posedge sys_clk) begin
		csr.csr_dr <= '0;
		if (bank_hit) begin
			case (reg_idx)
				REG_TMR_CTRL:    csr.csr_dr <= ctrl_word;
				REG_TMR_COMPARE: csr.csr_dr <= compare;
				REG_TMR_COUNTER: csr.csr_dr <= counter;
				default:         csr.csr_dr <= '0;
			endcase
		end
	end

endmodule

// File: rtl/irq_ctrl.sv
module irq_ctrl import sysctl_pkg::*; (
	input  logic     sys_clk,
	input  logic     sys_rst_i,
	input  irq_vec_t irq_src_i,
	output logic     irq_o,
	csr_bus_if.periph csr
);

	irq_vec_t pending;
	irq_vec_t mask;
	irq_vec_t pend_clr;

	logic                 bank_hit;
	logic [CSR_REG_W-1:0] reg_idx;

	assign bank_hit = (csr.csr_a[$bits(csr_adr_t)-1:CSR_REG_W] == CSR_BANK_IRQ);
	assign reg_idx  = csr.csr_a[CSR_REG_W-1:0];

	// Write-one-to-clear on the pending word
	assign pend_clr = (csr.csr_we && bank_hit && reg_idx == REG_IRQ_PENDING)
		? csr.csr_dw[$bits(irq_vec_t)-1:0] : '0;

	// ------------------------------
	// Pending, mask, output
	// ------------------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			pending <= '0;
			mask    <= '0;
			irq_o   <= 1'b0;
		end else begin
			// New event wins over a clear in the same cycle
			pending <= (pending & ~pend_clr) | irq_src_i;
			if (csr.csr_we && bank_hit && reg_idx == REG_IRQ_MASK) begin
				mask <= csr.csr_dw[$bits(irq_vec_t)-1:0];
			end
			irq_o <= |(pending & mask);
		end
	end

	// Read port
	always_ff @(posedge sys_clk) begin
		csr.csr_dr <= '0;
		if (bank_hit) begin
			case (reg_idx)
				REG_IRQ_PENDING: csr.csr_dr <= wb_dat_t'(pending);
				REG_IRQ_MASK:    csr.csr_dr <= wb_dat_t'(mask);
				default:         csr.csr_dr <= '0;
			endcase
		end
	end

endmodule

// File: rtl/sysctl_top.sv
module sysctl_top import sysctl_pkg::*; (
	input  logic      sys_clk,
	input  logic      trigger_reset,
	input  wb_adr_t   wb_adr_i,
	input  wb_dat_t   wb_dat_i,
	output wb_dat_t   wb_dat_o,
	input  logic      wb_we_i,
	input  logic      wb_cyc_i,
	input  logic      wb_stb_i,
	output logic      wb_ack_o,
	input  gpio_in_t  gpio_i,
	output gpio_out_t gpio_o,
	output logic      irq_o,
	output logic      boot_rst_n_o
);

	logic sys_rst;
	logic gpio_irq;
	logic timer0_irq;
	logic timer1_irq;

	// One CSR segment per peripheral
	csr_bus_if gpio_bus ();
	csr_bus_if tmr0_bus ();
	csr_bus_if tmr1_bus ();
	csr_bus_if irq_bus ();

	// ------------------------------
	// Reset and bus bridge
	// ------------------------------
	reset_seq u_reset_seq (
		.sys_clk      (sys_clk),
		.trigger_reset(trigger_reset),
		.sys_rst_o    (sys_rst),
		.boot_rst_n_o (boot_rst_n_o)
	);

	wb_csr_bridge u_bridge (
		.sys_clk  (sys_clk),
		.sys_rst_i(sys_rst),
		.wb_adr_i (wb_adr_i),
		.wb_dat_i (wb_dat_i),
		.wb_dat_o (wb_dat_o),
		.wb_we_i  (wb_we_i),
		.wb_cyc_i (wb_cyc_i),
		.wb_stb_i (wb_stb_i),
		.wb_ack_o (wb_ack_o),
		.gpio_bus (gpio_bus),
		.tmr0_bus (tmr0_bus),
		.tmr1_bus (tmr1_bus),
		.irq_bus  (irq_bus)
	);

	// ------------------------------
	// Peripherals
	// ------------------------------
	sysctl_gpio u_gpio (
		.sys_clk  (sys_clk),
		.sys_rst_i(sys_rst),
		.gpio_i   (gpio_i),
		.gpio_o   (gpio_o),
		.irq_o    (gpio_irq),
		.csr      (gpio_bus)
	);

	sysctl_timer #(.CSR_BANK(CSR_BANK_TIMER0)) u_timer0 (
		.sys_clk  (sys_clk),
		.sys_rst_i(sys_rst),
		.irq_o    (timer0_irq),
		.csr      (tmr0_bus)
	);

	sysctl_timer #(.CSR_BANK(CSR_BANK_TIMER1)) u_timer1 (
		.sys_clk  (sys_clk),
		.sys_rst_i(sys_rst),
		.irq_o    (timer1_irq),
		.csr      (tmr1_bus)
	);

	// Source order matches irq_vec_t
	irq_ctrl u_irq_ctrl (
		.sys_clk  (sys_clk),
		.sys_rst_i(sys_rst),
		.irq_src_i({timer1_irq, timer0_irq, gpio_irq}),
		.irq_o    (irq_o),
		.csr      (irq_bus)
	);

endmodule

// File: tb/tb_wb_tasks.svh
// Compare, stop at the first difference
task automatic check_value(input string name, input logic [31:0] actual,
	input logic [31:0] expected);
	if (actual !== expected) begin
		$display("Mismatch at %0d ns: %s is %h, expected %h", $time, name, actual, expected);
		$display("Test failures found");
		$fatal(1);
	end
endtask

// Ack looked at on falling edges where it is stable
task automatic wait_ack(input int limit, input wb_adr_t adr);
	int n;
	n = 0;
	@(negedge sys_clk);
	while (wb_ack !== 1'b1) begin
		if (n >= limit) begin
			$display("Timeout: no Wishbone ack for address %h within %0d cycles", adr, limit);
			$display("Test failures found");
			$fatal(1);
		end
		n++;
		@(negedge sys_clk);
	end
endtask

// ------------------------------
// Wishbone classic master
// ------------------------------
// Request held until ack, dropped on the edge that ends the ack cycle
task automatic wb_write(input wb_adr_t adr, input wb_dat_t dat);
	@(posedge sys_clk);
	wb_adr   <= adr;
	wb_dat_w <= dat;
	wb_we    <= 1'b1;
	wb_cyc   <= 1'b1;
	wb_stb   <= 1'b1;
	wait_ack(ACK_LIMIT, adr);
	@(posedge sys_clk);
	wb_cyc <= 1'b0;
	wb_stb <= 1'b0;
	wb_we  <= 1'b0;
endtask

// Data taken in the ack cycle
task automatic wb_read(input wb_adr_t adr, input int limit, output wb_dat_t dat);
	@(posedge sys_clk);
	wb_adr <= adr;
	wb_we  <= 1'b0;
	wb_cyc <= 1'b1;
	wb_stb <= 1'b1;
	wait_ack(limit, adr);
	dat = wb_dat_r;
	@(posedge sys_clk);
	wb_cyc <= 1'b0;
	wb_stb <= 1'b0;
endtask

// File: tb/tb_sysctl.sv
module tb_sysctl import sysctl_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	// Ack arrives a few cycles after the strobe
	localparam int ACK_LIMIT = 16;

	typedef enum logic [2:0] {
		OP_WRITE,
		OP_READ,
		OP_WAIT_IRQ,
		OP_SET_GPIO,
		OP_IDLE
	} op_t;

	logic      sys_clk = 1'b0;
	logic      trigger_reset;
	wb_adr_t   wb_adr;
	wb_dat_t   wb_dat_w;
	wb_dat_t   wb_dat_r;
	logic      wb_we;
	logic      wb_cyc;
	logic      wb_stb;
	logic      wb_ack;
	gpio_in_t  gpio_in;
	gpio_out_t gpio_out;
	logic      irq;
	logic      boot_rst_n;

	// Edges since the trigger dropped
	int        cycle_cnt = 0;
	int        seed;
	gpio_in_t  gpio_drv;

	// Stimulus table, one step per index
	op_t       tab_op[$];
	wb_adr_t   tab_adr[$];
	wb_dat_t   tab_dat[$];
	wb_dat_t   tab_exp[$];

	`include "tb_wb_tasks.svh"

	always #50 sys_clk = ~sys_clk;

	always @(posedge sys_clk) begin
		if (trigger_reset) begin
			cycle_cnt <= 0;
		end else begin
			cycle_cnt <= cycle_cnt + 1;
		end
	end

	sysctl_top i_dut (
		.sys_clk      (sys_clk),
		.trigger_reset(trigger_reset),
		.wb_adr_i     (wb_adr),
		.wb_dat_i     (wb_dat_w),
		.wb_dat_o     (wb_dat_r),
		.wb_we_i      (wb_we),
		.wb_cyc_i     (wb_cyc),
		.wb_stb_i     (wb_stb),
		.wb_ack_o     (wb_ack),
		.gpio_i       (gpio_in),
		.gpio_o       (gpio_out),
		.irq_o        (irq),
		.boot_rst_n_o (boot_rst_n)
	);

	// Byte address from bank and word index, bits 11:2 carry the CSR word
	function automatic wb_adr_t byte_addr(input logic [3:0] bank, input logic [5:0] idx);
		return {20'd0, bank, idx, 2'b00};
	endfunction

	task automatic add_step(input op_t op, input wb_adr_t adr, input wb_dat_t dat,
		input wb_dat_t exp);
		tab_op.push_back(op);
		tab_adr.push_back(adr);
		tab_dat.push_back(dat);
		tab_exp.push_back(exp);
	endtask

	// Level check, limit of 0 means right now
	task automatic wait_irq(input logic level, input int limit);
		int n;
		n = 0;
		@(negedge sys_clk);
		while (irq !== level) begin
			if (n >= limit) begin
				$display("Timeout: irq_o did not reach %0d within %0d cycles", level, limit);
				$display("Test failures found");
				$fatal(1);
			end
			n++;
			@(negedge sys_clk);
		end
	endtask

	task automatic build_table();
		// Register access and unmapped space
		add_step(OP_WRITE, byte_addr(CSR_BANK_GPIO, REG_GPIO_OUT), 32'h0000_00a6, 0);
		add_step(OP_READ, byte_addr(CSR_BANK_GPIO, REG_GPIO_OUT), 0, 32'h2);
		add_step(OP_WRITE, byte_addr(CSR_BANK_TIMER0, REG_TMR_COMPARE), 32'h1234_5678, 0);
		add_step(OP_READ, byte_addr(CSR_BANK_TIMER0, REG_TMR_COMPARE), 0, 32'h1234_5678);
		add_step(OP_WRITE, byte_addr(CSR_BANK_TIMER1, REG_TMR_COMPARE), 32'hcafe_0011, 0);
		add_step(OP_READ, byte_addr(CSR_BANK_TIMER1, REG_TMR_COMPARE), 0, 32'hcafe_0011);
		add_step(OP_READ, byte_addr(4'd5, 6'd0), 0, 0);
		add_step(OP_READ, byte_addr(CSR_BANK_GPIO, 6'd3), 0, 0);
		// GPIO input, change event, write-one-to-clear
		add_step(OP_SET_GPIO, 0, 0, 0);
		add_step(OP_READ, byte_addr(CSR_BANK_GPIO, REG_GPIO_IN), 0, 0);
		add_step(OP_READ, byte_addr(CSR_BANK_IRQ, REG_IRQ_PENDING), 0, 32'h1);
		add_step(OP_WRITE, byte_addr(CSR_BANK_IRQ, REG_IRQ_PENDING), 32'h1, 0);
		add_step(OP_READ, byte_addr(CSR_BANK_IRQ, REG_IRQ_PENDING), 0, 0);
		// Timer 0 one-shot, match at 20
		add_step(OP_WRITE, byte_addr(CSR_BANK_TIMER0, REG_TMR_COMPARE), 32'd20, 0);
		add_step(OP_WRITE, byte_addr(CSR_BANK_IRQ, REG_IRQ_MASK), 32'h2, 0);
		add_step(OP_WRITE, byte_addr(CSR_BANK_TIMER0, REG_TMR_CTRL), 32'h1, 0);
		add_step(OP_WAIT_IRQ, 0, 60, 1);
		add_step(OP_READ, byte_addr(CSR_BANK_TIMER0, REG_TMR_CTRL), 0, 0);
		add_step(OP_READ, byte_addr(CSR_BANK_TIMER0, REG_TMR_COUNTER), 0, 0);
		// Timer 1 autorestart, masked off then unmasked
		add_step(OP_WRITE, byte_addr(CSR_BANK_IRQ, REG_IRQ_PENDING), 32'h2, 0);
		add_step(OP_WAIT_IRQ, 0, 8, 0);
		add_step(OP_WRITE, byte_addr(CSR_BANK_TIMER1, REG_TMR_COMPARE), 32'd10, 0);
		add_step(OP_WRITE, byte_addr(CSR_BANK_TIMER1, REG_TMR_CTRL), 32'h3, 0);
		add_step(OP_IDLE, 0, 30, 0);
		add_step(OP_READ, byte_addr(CSR_BANK_IRQ, REG_IRQ_PENDING), 0, 32'h4);
		add_step(OP_WAIT_IRQ, 0, 0, 0);
		add_step(OP_WRITE, byte_addr(CSR_BANK_IRQ, REG_IRQ_MASK), 32'h6, 0);
		add_step(OP_WAIT_IRQ, 0, 20, 1);
		add_step(OP_READ, byte_addr(CSR_BANK_TIMER1, REG_TMR_CTRL), 0, 32'h3);
	endtask

	initial begin
		wb_dat_t  rdat;
		wb_dat_t  exp;
		gpio_in_t gpio_new;
		trigger_reset = 1'b1;
		wb_adr        = '0;
		wb_dat_w      = '0;
		wb_we         = 1'b0;
		wb_cyc        = 1'b0;
		wb_stb        = 1'b0;
		gpio_in       = '0;
		gpio_drv      = '0;
		seed          = 32'h20d7_0b76;
		build_table();

		// ------------------------------
		// Reset staging
		// ------------------------------
		repeat (8) @(posedge sys_clk);
		trigger_reset <= 1'b0;
		repeat (100) @(posedge sys_clk);
		@(negedge sys_clk);
		check_value("boot_rst_n_o after 100 cycles", boot_rst_n, 0);
		repeat (40) @(posedge sys_clk);
		@(negedge sys_clk);
		check_value("boot_rst_n_o after 140 cycles", boot_rst_n, 1);
		// Issued while the system reset still holds
		wb_read(byte_addr(CSR_BANK_GPIO, REG_GPIO_OUT), 400, rdat);
		check_value("ack after system reset release", cycle_cnt > SYS_RST_CYCLES, 1);
		check_value("wb_dat_o of first read", rdat, 0);

		// ------------------------------
		// Table steps
		// ------------------------------
		for (int i = 0; i < tab_op.size(); i++) begin
			case (tab_op[i])
				OP_WRITE: wb_write(tab_adr[i], tab_dat[i]);
				OP_READ: begin
					exp = tab_exp[i];
					// Input register follows the last driven pins
					if (tab_adr[i] == byte_addr(CSR_BANK_GPIO, REG_GPIO_IN)) begin
						exp = wb_dat_t'(gpio_drv);
					end
					wb_read(tab_adr[i], ACK_LIMIT, rdat);
					check_value($sformatf("wb_dat_o at %h", tab_adr[i]), rdat, exp);
					if (tab_adr[i] == byte_addr(CSR_BANK_GPIO, REG_GPIO_OUT)) begin
						check_value("gpio_o", gpio_out, exp);
					end
				end
				OP_WAIT_IRQ: wait_irq(tab_exp[i][0], tab_dat[i]);
				OP_SET_GPIO: begin
					gpio_new = gpio_in_t'($random(seed));
					// Must differ so the change event fires
					if (gpio_new == gpio_drv) begin
						gpio_new = ~gpio_new;
					end
					@(posedge sys_clk);
					gpio_in <= gpio_new;
					gpio_drv = gpio_new;
					// Two sync stages plus event and pending
					repeat (4) @(posedge sys_clk);
				end
				OP_IDLE: repeat (tab_dat[i]) @(posedge sys_clk);
				default: ;
			endcase
		end

		$display("All tests passed!");
		$finish;
	end

endmodule

// File: flist.f
+incdir+tb
rtl/sysctl_pkg.sv
rtl/csr_bus_if.sv
rtl/reset_seq.sv
rtl/wb_csr_bridge.sv
rtl/sysctl_gpio.sv
rtl/sysctl_timer.sv
rtl/irq_ctrl.sv
rtl/sysctl_top.sv
tb/tb_sysctl.sv
